// File: hw/videoTxPkg.sv
// Video transmit shared types for pixel data, timing counts and backlight duty

package videoTxPkg;

	// ------------------------------
	// Colour data
	// ------------------------------

	// One 4-bit colour channel
	typedef logic [3:0] channelT;

	// Packed RGB 4:4:4, red in [11:8], green in [7:4], blue in [3:0]
	typedef logic [11:0] pixelT;

	// ------------------------------
	// Timing counts
	// ------------------------------

	// Horizontal position, one bit wider than display width
	typedef logic [11:0] hCoordT;

	// Vertical position in lines
	typedef logic [11:0] vCoordT;

	// Backlight duty ratio, 0 is dark
	typedef logic [7:0] dutyT;

	// Vertical phase of the sync generator
	typedef enum logic [1:0] {
		active,
		frontPorch,
		sync,
		backPorch
	} syncStateT;

endpackage

// File: hw/videoTimingIf.sv
// Display and sync timing set shared by the pixel generator and sync generator
`timescale 1ns/1ps

interface videoTimingIf import videoTxPkg::*; ();

	// Active area size
	hCoordT hDisplay;
	vCoordT vDisplay;

	// Horizontal sync window and line length in pixels
	hCoordT hSyncStart;
	hCoordT hSyncEnd;
	hCoordT hSyncMax;

	// Vertical sync window and frame length in lines
	vCoordT vSyncStart;
	vCoordT vSyncEnd;
	vCoordT vSyncMax;

	// Pattern source only needs the raster size
	modport pixelSide (
		input hDisplay,
		input vDisplay
	);

	// Sync generator sees the full set
	modport syncSide (
		input hDisplay, vDisplay,
		input hSyncStart, hSyncEnd, hSyncMax,
		input vSyncStart, vSyncEnd, vSyncMax
	);

endinterface

// File: hw/videoPixelGen.sv
// Test-pattern pixel source writing one raster-order pixel per cycle into the FIFO
`timescale 1ns/1ps

module videoPixelGen import videoTxPkg::*; (
	input  logic            iVideoClk,
	input  logic            rstN,
	videoTimingIf.pixelSide timing,
	input  logic            full,
	output pixelT           pixel,
	output logic            pixelWe
);

	// ------------------------------
	// Raster position and frame
	// ------------------------------

	hCoordT xPos;
	vCoordT yPos;
	logic [3:0] frameCnt;

	// Last pixel of a line and last line of a frame
	hCoordT xLast;
	vCoordT yLast;
	logic lineDone;
	logic frameDone;

	assign xLast = timing.hDisplay - hCoordT'(1);
	assign yLast = timing.vDisplay - vCoordT'(1);
	assign lineDone = (xPos == xLast);
	assign frameDone = lineDone && (yPos == yLast);

	// Write whenever there is room
	assign pixelWe = ~full;

	// Pattern: red from x, green from y, blue from frame
	assign pixel = {channelT'(xPos[3:0]), channelT'(yPos[3:0]), channelT'(frameCnt)};

	// ------------------------------
	// Position counters
	// ------------------------------

	// Advance only on accepted writes
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			xPos     <= '0;
			yPos     <= '0;
			frameCnt <= '0;
		end
		else if (pixelWe)
		begin
			if (lineDone)
				xPos <= '0;
			else
				xPos <= xPos + hCoordT'(1);

			// Next line or wrap to top
			if (frameDone)
				yPos <= '0;
			else if (lineDone)
				yPos <= yPos + vCoordT'(1);

			// Frame index wraps at 16
			if (frameDone)
				frameCnt <= frameCnt + 4'd1;
		end
	end

endmodule

// File: hw/videoPixelFifo.sv
// Single-clock pixel FIFO with a registered read port that idles at zero
`timescale 1ns/1ps

module videoPixelFifo import videoTxPkg::*; #(
	parameter int pFifoDepth = 16
) (
	input  logic  iVideoClk,
	input  logic  rstN,
	input  pixelT wrData,
	input  logic  wrEn,
	output logic  full,
	input  logic  rdEn,
	output pixelT rdData
);

	// Depth is a power of two
	localparam int lpAddrW = $clog2(pFifoDepth);

	// ------------------------------
	// Storage and pointers
	// ------------------------------

	pixelT mem [pFifoDepth];

	// Extra top bit tells full from empty
	logic [lpAddrW:0] wrPtr;
	logic [lpAddrW:0] rdPtr;
	logic empty;
	logic wrAccept;
	logic rdAccept;

	assign empty = (wrPtr == rdPtr);
	assign full  = (wrPtr[lpAddrW] != rdPtr[lpAddrW])
		&& (wrPtr[lpAddrW-1:0] == rdPtr[lpAddrW-1:0]);

	// Writes to a full FIFO and pops from an empty one are dropped
	assign wrAccept = wrEn && !full;
	assign rdAccept = rdEn && !empty;

	// Word store
	always_ff @(posedge iVideoClk)
	begin
		if (wrAccept)
			mem[wrPtr[lpAddrW-1:0]] <= wrData;
	end

	// ------------------------------
	// Pointer update and read port
	// ------------------------------

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			rdData <= '0;
		end
		else
		begin
			if (wrAccept)
				wrPtr <= wrPtr + 1'b1;

			// Popped word one cycle after rdEn, black otherwise
			if (rdAccept)
			begin
				rdPtr  <= rdPtr + 1'b1;
				rdData <= mem[rdPtr[lpAddrW-1:0]];
			end
			else
				rdData <= '0;
		end
	end

endmodule

// File: hw/videoSyncGen.sv
// Raster timing generator producing FIFO read enable, HSync, VSync, DE and frame end
`timescale 1ns/1ps

module videoSyncGen import videoTxPkg::*; (
	input  logic           iVideoClk,
	input  logic           rstN,
	videoTimingIf.syncSide timing,
	output logic           readEn,
	output logic           hSync,
	output logic           vSync,
	output logic           de,
	output logic           frameEnd
);

	// ------------------------------
	// Counters
	// ------------------------------

	hCoordT hCount;
	vCoordT vCount;
	hCoordT hLast;
	vCoordT vLast;
	vCoordT nextLine;
	logic lineEnd;

	syncStateT vState;
	syncStateT vStateNext;

	// Unregistered decode of the current position
	logic hSyncNow;
	logic deNow;

	assign hLast   = timing.hSyncMax - hCoordT'(1);
	assign vLast   = timing.vSyncMax - vCoordT'(1);
	assign lineEnd = (hCount == hLast);

	// Line entered at the end of this one
	assign nextLine = (vCount == vLast) ? '0 : vCount + vCoordT'(1);

	// Phase a given line belongs to, skips empty porches
	function automatic syncStateT phaseOf(vCoordT line);
		if (line < timing.vDisplay)
			return active;
		else if (line < timing.vSyncStart)
			return frontPorch;
		else if (line < timing.vSyncEnd)
			return sync;
		else
			return backPorch;
	endfunction

	// ------------------------------
	// Vertical phase FSM
	// ------------------------------

	// Moves only on line boundaries
	always_comb
	begin
		vStateNext = vState;
		if (lineEnd)
		begin
			if (nextLine == '0)
				vStateNext = active;
			else
			begin
				case (vState)
					active:     if (nextLine == timing.vDisplay) vStateNext = phaseOf(nextLine);
					frontPorch: if (nextLine == timing.vSyncStart) vStateNext = phaseOf(nextLine);
					sync:       if (nextLine == timing.vSyncEnd) vStateNext = phaseOf(nextLine);
					default:    vStateNext = vState;
				endcase
			end
		end
	end

	// Start in vertical blanking so the FIFO can fill
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCount <= '0;
			vCount <= timing.vDisplay;
			vState <= phaseOf(timing.vDisplay);
		end
		else
		begin
			hCount <= lineEnd ? '0 : hCount + hCoordT'(1);
			if (lineEnd)
				vCount <= nextLine;
			vState <= vStateNext;
		end
	end

	// ------------------------------
	// Sync and DE outputs
	// ------------------------------

	assign hSyncNow = (hCount >= timing.hSyncStart) && (hCount < timing.hSyncEnd);
	assign deNow    = (hCount < timing.hDisplay) && (vState == active);

	// FIFO pop in the cycle the counters enter an active pixel
	assign readEn = deNow;

	// One stage to line up with FIFO read data
	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hSync    <= 1'b0;
			vSync    <= 1'b0;
			de       <= 1'b0;
			frameEnd <= 1'b0;
		end
		else
		begin
			hSync    <= hSyncNow;
			vSync    <= (vState == sync);
			de       <= deNow;
			// Last position of the frame
			frameEnd <= lineEnd && (vCount == vLast);
		end
	end

endmodule

// File: hw/backlightPwm.sv
// Backlight dimming PWM with a 256-cycle period
`timescale 1ns/1ps

module backlightPwm import videoTxPkg::*; (
	input  logic iVideoClk,
	input  logic rstN,
	input  dutyT duty,
	output logic pwm
);

	// Free period counter, wraps 255 to 0
	logic [7:0] periodCnt;

	// Duty held for a whole period
	dutyT dutyLatch;

	// Fresh duty applies from count zero
	dutyT dutyNow;

	assign dutyNow = (periodCnt == 8'd0) ? duty : dutyLatch;

	always_ff @(posedge iVideoClk or negedge rstN)
	begin
		if (!rstN)
		begin
			periodCnt <= '0;
			dutyLatch <= '0;
			pwm       <= 1'b0;
		end
		else
		begin
			periodCnt <= periodCnt + 8'd1;

			// Sample once per period
			if (periodCnt == 8'd0)
				dutyLatch <= duty;

			// High for duty counts, zero stays dark
			pwm <= (periodCnt < dutyNow);
		end
	end

endmodule

// File: hw/videoTxUnit.sv
// TFT video transmit top with pattern source, pixel FIFO, sync timing and backlight
`timescale 1ns/1ps

module videoTxUnit import videoTxPkg::*; #(
	parameter int pFifoDepth = 16
) (
	// TFT panel side
	output channelT oTftColorR,
	output channelT oTftColorG,
	output channelT oTftColorB,
	output logic    oTftDclk,
	output logic    oTftHSync,
	output logic    oTftVSync,
	output logic    oTftDe,
	output logic    oTftBackLight,
	output logic    oTftRst,
	output logic    oFe,
	// Run-time timing set
	input  hCoordT  iHdisplay,
	input  hCoordT  iHSyncStart,
	input  hCoordT  iHSyncEnd,
	input  hCoordT  iHSyncMax,
	input  vCoordT  iVdisplay,
	input  vCoordT  iVSyncStart,
	input  vCoordT  iVSyncEnd,
	input  vCoordT  iVSyncMax,
	// Control
	input  dutyT    iBlDutyRatio,
	input  logic    iDisplayRst,
	input  logic    iVideoClk,
	input  logic    rstN
);

	// ------------------------------
	// Timing set distribution
	// ------------------------------

	videoTimingIf timing ();

	assign timing.hDisplay   = iHdisplay;
	assign timing.vDisplay   = iVdisplay;
	assign timing.hSyncStart = iHSyncStart;
	assign timing.hSyncEnd   = iHSyncEnd;
	assign timing.hSyncMax   = iHSyncMax;
	assign timing.vSyncStart = iVSyncStart;
	assign timing.vSyncEnd   = iVSyncEnd;
	assign timing.vSyncMax   = iVSyncMax;

	// ------------------------------
	// Pixel path
	// ------------------------------

	pixelT genPixel;
	logic genWe;
	logic fifoFull;
	logic fifoRe;
	pixelT outPixel;

	// Raster-order pattern
	videoPixelGen uPixelGen (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.timing    (timing.pixelSide),
		.full      (fifoFull),
		.pixel     (genPixel),
		.pixelWe   (genWe)
	);

	// Elastic store between source and raster
	videoPixelFifo #(
		.pFifoDepth (pFifoDepth)
	) uPixelFifo (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.wrData    (genPixel),
		.wrEn      (genWe),
		.full      (fifoFull),
		.rdEn      (fifoRe),
		.rdData    (outPixel)
	);

	// Counters and registered sync outputs
	videoSyncGen uSyncGen (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.timing    (timing.syncSide),
		.readEn    (fifoRe),
		.hSync     (oTftHSync),
		.vSync     (oTftVSync),
		.de        (oTftDe),
		.frameEnd  (oFe)
	);

	// Split packed pixel into panel channels
	assign oTftColorR = outPixel[11:8];
	assign oTftColorG = outPixel[7:4];
	assign oTftColorB = outPixel[3:0];

	// ------------------------------
	// Backlight and panel control
	// ------------------------------

	backlightPwm uBacklight (
		.iVideoClk (iVideoClk),
		.rstN      (rstN),
		.duty      (iBlDutyRatio),
		.pwm       (oTftBackLight)
	);

	// Pixel clock and panel reset pass to the pins
	assign oTftDclk = iVideoClk;
	assign oTftRst  = iDisplayRst;

endmodule

// File: test/tbClockGen.sv
// Testbench clock and reset source, 20 ns period with a 16-cycle reset
`timescale 1ns/1ps

module tbClockGen (
	output logic clk,
	output logic rstN
);

	localparam int resetCycles = 16;

	// Free-running 50 MHz clock
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Release lands on a falling edge, away from flop updates
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

// File: test/videoTx_assert.sv
// Sync generator protocol checks for DE against sync pulses and frame end width
`timescale 1ns/1ps

module videoTxAssert (
	input logic iVideoClk,
	input logic rstN,
	input logic hSync,
	input logic vSync,
	input logic de,
	input logic frameEnd
);

	// ------------------------------
	// Blanking rules
	// ------------------------------

	// Active pixels stay clear of both sync pulses
	deOutsideHSync: assert property (@(posedge iVideoClk) disable iff (!rstN)
		de |-> !hSync)
		else $error("DE high while HSync is high");

	deOutsideVSync: assert property (@(posedge iVideoClk) disable iff (!rstN)
		de |-> !vSync)
		else $error("DE high while VSync is high");

	// ------------------------------
	// Frame end
	// ------------------------------

	// One cycle wide
	frameEndPulse: assert property (@(posedge iVideoClk) disable iff (!rstN)
		frameEnd |=> !frameEnd)
		else $error("frameEnd held longer than one cycle");

	// Last position of a frame is blanking
	frameEndBlank: assert property (@(posedge iVideoClk) disable iff (!rstN)
		frameEnd |-> !de)
		else $error("frameEnd raised on an active pixel");

endmodule

// Attach to every sync generator
bind videoSyncGen videoTxAssert uSyncAssert (
	.iVideoClk (iVideoClk),
	.rstN      (rstN),
	.hSync     (hSync),
	.vSync     (vSync),
	.de        (de),
	.frameEnd  (frameEnd)
);

// File: test/tbVideoTx.sv
// Video transmit testbench with pattern reference, sync and backlight checks
`timescale 1ns/1ps

module tbVideoTx import videoTxPkg::*; ();

	// Small raster of 8x4 active in a 14x7 frame
	localparam hCoordT hDisplayCfg   = 12'd8;
	localparam hCoordT hSyncStartCfg = 12'd9;
	localparam hCoordT hSyncEndCfg   = 12'd11;
	localparam hCoordT hSyncMaxCfg   = 12'd14;
	localparam vCoordT vDisplayCfg   = 12'd4;
	localparam vCoordT vSyncStartCfg = 12'd5;
	localparam vCoordT vSyncEndCfg   = 12'd6;
	localparam vCoordT vSyncMaxCfg   = 12'd7;

	channelT oTftColorR, oTftColorG, oTftColorB;
	logic oTftDclk, oTftHSync, oTftVSync, oTftDe, oTftBackLight, oTftRst, oFe;
	hCoordT iHdisplay, iHSyncStart, iHSyncEnd, iHSyncMax;
	vCoordT iVdisplay, iVSyncStart, iVSyncEnd, iVSyncMax;
	dutyT iBlDutyRatio;
	logic iDisplayRst, iVideoClk, rstN;

	integer seed;
	int mismatchCnt = 0;
	int otherErrCnt = 0;

	// Monitor tracking with frame index at 0 from the first oFe
	int xPos = 0;
	int yPos = 0;
	int frameIdx = -1;
	int deCnt = 0;
	int hsRun = 0;
	int vsLines = 0;
	int cycCnt = 0;
	logic prevHSync = 1'b0;

	tbClockGen uClock (
		.clk  (iVideoClk),
		.rstN (rstN)
	);

	videoTxUnit #(
		.pFifoDepth (16)
	) u_dut (.*);

	// ------------------------------
	// Reference and compare tasks
	// ------------------------------

	// Red from x, green from y and blue from frame
	function automatic pixelT refPixel(input int x, input int y, input int f);
		pixelT p;
		p[11:8] = x[3:0];
		p[7:4]  = y[3:0];
		p[3:0]  = f[3:0];
		return p;
	endfunction

	task automatic checkPixel(input string name, input pixelT got, input pixelT exp);
		if (got !== exp)
		begin
			mismatchCnt++;
			$display("Mismatch %s: got 0x%03h expected 0x%03h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatchCnt++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input hCoordT got, input hCoordT exp);
		if (got !== exp)
		begin
			mismatchCnt++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic reportError(input string msg);
		otherErrCnt++;
		$display("Error: %s", msg);
	endtask

	// Panel outputs quiet and panel reset passed through
	task automatic checkResetLow();
		checkFlag("oTftHSync", oTftHSync, 1'b0);
		checkFlag("oTftVSync", oTftVSync, 1'b0);
		checkFlag("oTftDe", oTftDe, 1'b0);
		checkFlag("oTftBackLight", oTftBackLight, 1'b0);
		checkFlag("oTftRst", oTftRst, iDisplayRst);
		checkPixel("oTftColor", {oTftColorR, oTftColorG, oTftColorB}, '0);
	endtask

	// ------------------------------
	// Output monitor
	// ------------------------------

	always @(negedge iVideoClk)
	begin
		if (rstN)
		begin
			// Raster-order colour data and black outside DE
			if (oTftDe)
			begin
				checkPixel("oTftColor", {oTftColorR, oTftColorG, oTftColorB},
					refPixel(xPos, yPos, frameIdx));
				deCnt++;
				if (xPos == int'(hDisplayCfg) - 1)
				begin
					xPos = 0;
					yPos++;
				end
				else
					xPos++;
			end
			else
				checkPixel("oTftColor blank", {oTftColorR, oTftColorG, oTftColorB}, '0);

			// HSync run length checked on its falling edge
			if (oTftHSync)
				hsRun++;
			else if (prevHSync)
			begin
				checkCount("hSync width", hCoordT'(hsRun), hSyncEndCfg - hSyncStartCfg);
				hsRun = 0;
			end
			// A line under VSync is one HSync rise
			if (oTftHSync && !prevHSync && oTftVSync)
				vsLines++;
			prevHSync = oTftHSync;
			cycCnt++;

			// First oFe only closes the partial frame after reset
			if (oFe)
			begin
				if (frameIdx >= 0)
				begin
					checkCount("de cycles per frame", hCoordT'(deCnt),
						hCoordT'(hDisplayCfg * vDisplayCfg));
					checkCount("vSync lines", hCoordT'(vsLines),
						hCoordT'(vSyncEndCfg - vSyncStartCfg));
					checkCount("frame period", hCoordT'(cycCnt),
						hCoordT'(hSyncMaxCfg * vSyncMaxCfg));
				end
				frameIdx++;
				xPos = 0;
				yPos = 0;
				deCnt = 0;
				vsLines = 0;
				cycCnt = 0;
			end
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial
	begin
		int waitCnt;
		int highCnt;
		dutyT dutyList [4];

		// All inputs set before the first edge
		iHdisplay    = hDisplayCfg;
		iHSyncStart  = hSyncStartCfg;
		iHSyncEnd    = hSyncEndCfg;
		iHSyncMax    = hSyncMaxCfg;
		iVdisplay    = vDisplayCfg;
		iVSyncStart  = vSyncStartCfg;
		iVSyncEnd    = vSyncEndCfg;
		iVSyncMax    = vSyncMaxCfg;
		iBlDutyRatio = '0;
		iDisplayRst  = 1'b1;
		seed         = 90065;

		// Outputs held low during reset
		repeat (6)
		begin
			@(negedge iVideoClk);
			checkResetLow();
		end

		waitCnt = 0;
		while (!rstN && waitCnt < 1000)
		begin
			#1;
			waitCnt++;
		end
		if (!rstN)
			reportError("reset was never released");
		// Still quiet before the first clock edge out of reset
		checkResetLow();

		@(negedge iVideoClk);
		iDisplayRst = 1'b0;

		// Pixel clock and panel reset follow their sources
		@(posedge iVideoClk);
		#1;
		checkFlag("oTftDclk", oTftDclk, 1'b1);
		checkFlag("oTftRst", oTftRst, 1'b0);
		@(negedge iVideoClk);
		#1;
		checkFlag("oTftDclk", oTftDclk, 1'b0);

		// Backlight duty sweep over two random duties and both extremes
		dutyList[0] = dutyT'($random(seed));
		dutyList[1] = dutyT'($random(seed));
		dutyList[2] = 8'd0;
		dutyList[3] = 8'd255;
		foreach (dutyList[i])
		begin
			@(negedge iVideoClk);
			iBlDutyRatio = dutyList[i];
			// Let a full period pass on the new duty
			repeat (512) @(negedge iVideoClk);
			highCnt = 0;
			repeat (256)
			begin
				@(negedge iVideoClk);
				if (oTftBackLight)
					highCnt++;
			end
			checkCount("oTftBackLight high cycles", hCoordT'(highCnt), hCoordT'(dutyList[i]));
		end

		// At least three whole frames compared
		waitCnt = 0;
		while (frameIdx < 3 && waitCnt < 5000)
		begin
			@(posedge iVideoClk);
			waitCnt++;
		end
		if (frameIdx < 3)
			reportError("fewer than three frames were seen before the timeout");

		$display("Finished after %0d frames: %0d mismatches, %0d other errors",
			frameIdx, mismatchCnt, otherErrCnt);
		if (mismatchCnt == 0 && otherErrCnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: videoTx.f
hw/videoTxPkg.sv
hw/videoTimingIf.sv
hw/videoPixelGen.sv
hw/videoPixelFifo.sv
hw/videoSyncGen.sv
hw/backlightPwm.sv
hw/videoTxUnit.sv
test/tbClockGen.sv
test/videoTx_assert.sv
test/tbVideoTx.sv

// File: run.sh
#!/bin/sh
# Build the video transmit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbVideoTx -f videoTx.f -o simVideoTx
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

simOut=$(./obj_dir/simVideoTx)
status=$?
printf '%s\n' "$simOut"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "RESULT: PASS"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
